//--- cpu_fetch_pkg.sv
package cpu_fetch_pkg;

  // word width of registers and memory data
  localparam int data_w = 32;
  // byte-free word addressing on both ports
  localparam int addr_w = 32;

  // 16 registers, all mapped into data memory
  localparam int reg_num_w = 4;
  // register 15 holds the instruction pointer
  localparam logic [reg_num_w-1:0] reg_ip = 4'hf;

  // command queue between fetcher and operand reader
  localparam int queue_depth = 4;
  localparam int queue_ptr_w = 2;

  // command word, msb first
  // [31:28] code, [27:20] modify flags, [19:16] pointer bits, [15:0] register numbers
  typedef struct packed {
    logic [3:0]           cmd_code;
    logic [1:0]           cond_flags;
    logic [1:0]           d_flags;
    logic [1:0]           s0_flags;
    logic [1:0]           s1_flags;
    logic                 cond_ptr;
    logic                 d_ptr;
    logic                 s0_ptr;
    logic                 s1_ptr;
    logic [reg_num_w-1:0] cond_num;
    logic [reg_num_w-1:0] d_num;
    logic [reg_num_w-1:0] s0_num;
    logic [reg_num_w-1:0] s1_num;
  } cmd_word_t;

  // queued command plus the ip value after it
  typedef struct packed {
    cmd_word_t         cmd;
    logic [data_w-1:0] next_ip;
  } queue_entry_t;

  // operands ready for execution
  // dst is passed by number only, never read here
  typedef struct packed {
    logic [3:0]           cmd_code;
    logic [reg_num_w-1:0] dst_num;
    logic                 dst_ptr;
    logic [data_w-1:0]    cond;
    logic [data_w-1:0]    src1;
    logic [data_w-1:0]    src0;
  } operand_bundle_t;

endpackage

//--- cmd_queue_if.sv
interface cmd_queue_if import cpu_fetch_pkg::*; ();

  // write side, from the command fetcher
  logic         push;
  queue_entry_t push_entry;
  // no push while set
  logic         full;

  // read side, to the operand fetcher
  logic         pop;
  // oldest entry, valid while empty is low
  queue_entry_t pop_entry;
  logic         empty;

  modport producer (
    output push,
    output push_entry,
    input  full
  );

  modport consumer (
    output pop,
    input  pop_entry,
    input  empty
  );

  // the FIFO itself
  modport queue (
    input  push,
    input  push_entry,
    output full,
    input  pop,
    output pop_entry,
    output empty
  );

endinterface

//--- cmd_fetcher.sv
module cmd_fetcher import cpu_fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              run,
  input  logic [addr_w-1:0] base_addr,
  output logic              cmd_read_q,
  output logic [addr_w-1:0] cmd_addr,
  input  logic              cmd_read_dn,
  input  logic [data_w-1:0] cmd_data,
  cmd_queue_if.producer     q
);

  // instruction pointer, relative to base_addr
  logic [addr_w-1:0] ip;
  // ip after post-increment
  logic [addr_w-1:0] ip_next;
  // last cycle of a fetch
  logic              fetch_done;

  assign ip_next = ip + addr_w'(1);
  assign fetch_done = cmd_read_q && cmd_read_dn;

  // ip only moves on done, so the address holds for the whole request
  assign cmd_addr = base_addr + ip;

  // request FSM, idle or waiting for done
  always_ff @(posedge clk) begin
    if (rst) begin
      ip <= '0;
      cmd_read_q <= 1'b0;
    end else if (fetch_done) begin
      // fixed post-increment, like the ip register
      ip <= ip_next;
      // drop the request for at least one cycle
      cmd_read_q <= 1'b0;
    end else if (!cmd_read_q && run && !q.full) begin
      // new fetch only with room in the queue
      cmd_read_q <= 1'b1;
    end
  end

  // push straight from the memory data in the done cycle
  // full cannot rise mid-fetch, nobody else pushes
  assign q.push = fetch_done;

  // entry carries the ip that follows this command
  assign q.push_entry = '{
    cmd:     cmd_word_t'(cmd_data),
    next_ip: data_w'(ip_next)
  };

  // address must not move until the memory answers
  a_cmd_addr_stable: assert property (
    @(posedge clk) disable iff (rst)
    cmd_read_q && !cmd_read_dn |=> $stable(cmd_addr)
  );

endmodule

//--- cmd_queue.sv
module cmd_queue import cpu_fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  cmd_queue_if.queue q
);

  // entry storage, no reset needed
  queue_entry_t mem [queue_depth];

  // circular indices, wrap with the depth
  logic [queue_ptr_w-1:0] wr_idx;
  logic [queue_ptr_w-1:0] rd_idx;
  // one bit wider to tell full from empty
  logic [queue_ptr_w:0]   count;

  // write port
  always_ff @(posedge clk) begin
    if (q.push) begin
      mem[wr_idx] <= q.push_entry;
    end
  end

  // index and fill level
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_idx <= '0;
      rd_idx <= '0;
      count <= '0;
    end else begin
      if (q.push) begin
        wr_idx <= wr_idx + 1'b1;
      end
      if (q.pop) begin
        rd_idx <= rd_idx + 1'b1;
      end
      // push and pop together keep the level
      case ({q.push, q.pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign q.full = (int'(count) == queue_depth);
  assign q.empty = (count == '0);

  // head of queue, seen one cycle after its push
  assign q.pop_entry = mem[rd_idx];

  // fetcher has to watch full
  a_no_push_full: assert property (
    @(posedge clk) disable iff (rst)
    q.push |-> !q.full
  );

  // operand fetcher has to watch empty
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (rst)
    q.pop |-> !q.empty
  );

endmodule

//--- operand_fetcher.sv
module operand_fetcher import cpu_fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [addr_w-1:0] base_addr_data,
  cmd_queue_if.consumer     q,
  output logic              data_read_q,
  output logic [addr_w-1:0] data_addr,
  input  logic              data_read_dn,
  input  logic [data_w-1:0] data_data,
  output logic              operand_valid,
  output operand_bundle_t   operand_bundle
);

  // st_done only for commands without any memory operand
  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_done
  } state_t;

  // operand slots in read order: 0 cond, 1 src1, 2 src0
  function automatic logic [reg_num_w-1:0] op_num(cmd_word_t c, logic [1:0] i);
    case (i)
      2'd0: return c.cond_num;
      2'd1: return c.s1_num;
      default: return c.s0_num;
    endcase
  endfunction

  function automatic logic op_ptr(cmd_word_t c, logic [1:0] i);
    case (i)
      2'd0: return c.cond_ptr;
      2'd1: return c.s1_ptr;
      default: return c.s0_ptr;
    endcase
  endfunction

  // first slot at or after from that needs a memory read
  // 3 means nothing left
  function automatic logic [1:0] next_op(cmd_word_t c, logic [1:0] from);
    logic [1:0] sel;
    sel = 2'd3;
    for (int i = 2; i >= 0; i--) begin
      if (i >= int'(from) && op_num(c, 2'(i)) != reg_ip) begin
        sel = 2'(i);
      end
    end
    return sel;
  endfunction

  state_t               st;
  // command being worked on
  queue_entry_t         cur;
  // slot being read
  logic [1:0]           op_idx;
  // second read of a pointer operand
  logic                 indirect;
  // cond, src1, src0
  logic [data_w-1:0]    vals [3];

  logic [1:0]           first_idx;
  logic [1:0]           after_idx;
  logic [reg_num_w-1:0] cur_num;
  logic                 cur_ptr;
  logic                 read_done;

  // take a command as soon as we are free
  assign q.pop = (st == st_idle) && !q.empty;

  assign first_idx = next_op(q.pop_entry.cmd, 2'd0);
  assign after_idx = next_op(cur.cmd, op_idx + 2'd1);
  assign cur_num = op_num(cur.cmd, op_idx);
  assign cur_ptr = op_ptr(cur.cmd, op_idx);
  assign read_done = data_read_q && data_read_dn;

  // control
  always_ff @(posedge clk) begin
    if (rst) begin
      st <= st_idle;
      op_idx <= 2'd0;
      indirect <= 1'b0;
      data_read_q <= 1'b0;
      operand_valid <= 1'b0;
    end else begin
      operand_valid <= 1'b0;
      case (st)
        st_idle: begin
          if (q.pop) begin
            op_idx <= first_idx;
            indirect <= 1'b0;
            // all ip operands need no bus at all
            st <= (first_idx == 2'd3) ? st_done : st_read;
          end
        end
        st_read: begin
          if (read_done) begin
            // request falls right after done
            data_read_q <= 1'b0;
            if (!indirect && cur_ptr) begin
              indirect <= 1'b1;
            end else begin
              indirect <= 1'b0;
              op_idx <= after_idx;
              if (after_idx == 2'd3) begin
                st <= st_idle;
                operand_valid <= 1'b1;
              end
            end
          end else if (!data_read_q) begin
            data_read_q <= 1'b1;
          end
        end
        st_done: begin
          st <= st_idle;
          operand_valid <= 1'b1;
        end
        default: st <= st_idle;
      endcase
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (q.pop) begin
      cur <= q.pop_entry;
      // ip slots keep this value, the others get overwritten by reads
      for (int i = 0; i < 3; i++) begin
        vals[i] <= q.pop_entry.next_ip;
      end
    end else if (read_done) begin
      // direct value doubles as the pointer for the second read
      vals[op_idx] <= data_data;
    end
    // address set together with the request
    if (st == st_read && !data_read_q) begin
      data_addr <= base_addr_data +
                   (indirect ? addr_w'(vals[op_idx]) : addr_w'(cur_num));
    end
  end

  assign operand_bundle = '{
    cmd_code: cur.cmd.cmd_code,
    dst_num:  cur.cmd.d_num,
    dst_ptr:  cur.cmd.d_ptr,
    cond:     vals[0],
    src1:     vals[1],
    src0:     vals[2]
  };

  // address held until done
  a_data_addr_stable: assert property (
    @(posedge clk) disable iff (rst)
    data_read_q && !data_read_dn |=> $stable(data_addr)
  );

endmodule

//--- fetch_unit.sv
module fetch_unit import cpu_fetch_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 run,
  input  logic [addr_w-1:0]    base_addr,
  input  logic [addr_w-1:0]    base_addr_data,

  // instruction memory, read only
  output logic                 cmd_read_q,
  output logic [addr_w-1:0]    cmd_addr,
  input  logic                 cmd_read_dn,
  input  logic [data_w-1:0]    cmd_data,

  // data memory holding the registers, read only
  output logic                 data_read_q,
  output logic [addr_w-1:0]    data_addr,
  input  logic                 data_read_dn,
  input  logic [data_w-1:0]    data_data,

  // one-cycle pulse per command
  output logic                 operand_valid,
  output logic [3:0]           op_cmd_code,
  output logic [reg_num_w-1:0] op_dst_num,
  output logic                 op_dst_ptr,
  output logic [data_w-1:0]    op_cond,
  output logic [data_w-1:0]    op_src1,
  output logic [data_w-1:0]    op_src0
);

  operand_bundle_t operand_bundle;

  // fetcher to operand reader
  cmd_queue_if q_if ();

  cmd_fetcher i_cmd_fetcher (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .base_addr   (base_addr),
    .cmd_read_q  (cmd_read_q),
    .cmd_addr    (cmd_addr),
    .cmd_read_dn (cmd_read_dn),
    .cmd_data    (cmd_data),
    .q           (q_if.producer)
  );

  cmd_queue i_cmd_queue (
    .clk (clk),
    .rst (rst),
    .q   (q_if.queue)
  );

  operand_fetcher i_operand_fetcher (
    .clk            (clk),
    .rst            (rst),
    .base_addr_data (base_addr_data),
    .q              (q_if.consumer),
    .data_read_q    (data_read_q),
    .data_addr      (data_addr),
    .data_read_dn   (data_read_dn),
    .data_data      (data_data),
    .operand_valid  (operand_valid),
    .operand_bundle (operand_bundle)
  );

  // flatten the bundle for the outside
  assign op_cmd_code = operand_bundle.cmd_code;
  assign op_dst_num = operand_bundle.dst_num;
  assign op_dst_ptr = operand_bundle.dst_ptr;
  assign op_cond = operand_bundle.cond;
  assign op_src1 = operand_bundle.src1;
  assign op_src0 = operand_bundle.src0;

endmodule

//--- tb_mem.sv
module tb_mem import cpu_fetch_pkg::*; #(
  parameter string port_name = "mem"
) (
  input  logic              clk,
  input  logic              rst,
  // longest done delay in cycles
  input  int unsigned       max_delay,
  input  logic              read_q,
  input  logic [addr_w-1:0] addr,
  // content at addr, computed by the testbench
  input  logic [data_w-1:0] word,
  output logic              read_dn,
  output logic [data_w-1:0] data,
  output int                rule_errors
);

  // cycles left until done
  int unsigned wait_left;
  logic        busy;

  // data only valid in the done cycle
  assign data = read_dn ? word : '0;

  // done 0 to max_delay cycles after the request rises
  initial begin
    read_dn = 1'b0;
    busy = 1'b0;
    wait_left = 0;
    rule_errors = 0;
    forever begin
      @(posedge clk);
      #1;
      if (rst || read_dn) begin
        read_dn = 1'b0;
        busy = 1'b0;
      end else if (busy) begin
        wait_left--;
        if (wait_left == 0) begin
          read_dn = 1'b1;
        end
      end else if (read_q) begin
        busy = 1'b1;
        wait_left = $urandom_range(max_delay, 0);
        if (wait_left == 0) begin
          read_dn = 1'b1;
        end
      end
    end
  end

  // request and address held until done
  a_req_held: assert property (
    @(posedge clk) disable iff (rst)
    read_q && !read_dn |=> read_q && $stable(addr)
  ) else begin
    rule_errors++;
    $display("%0t: %s request dropped or address moved before done", $time, port_name);
  end

  // request falls right after done
  a_req_drop: assert property (
    @(posedge clk) disable iff (rst)
    read_q && read_dn |=> !read_q
  ) else begin
    rule_errors++;
    $display("%0t: %s request still high after its done cycle", $time, port_name);
  end

  // done never without a request
  a_dn_with_req: assert property (
    @(posedge clk) disable iff (rst)
    read_dn |-> read_q
  ) else begin
    rule_errors++;
    $display("%0t: %s done seen without a request", $time, port_name);
  end

endmodule

//--- tb_fetch_unit.sv
module tb_fetch_unit import cpu_fetch_pkg::*; ();

  logic                 clk;
  logic                 rst;
  logic                 run;
  logic [addr_w-1:0]    base_addr;
  logic [addr_w-1:0]    base_addr_data;
  logic                 cmd_read_q;
  logic [addr_w-1:0]    cmd_addr;
  logic                 cmd_read_dn;
  logic [data_w-1:0]    cmd_data;
  logic [data_w-1:0]    cmd_word;
  logic                 data_read_q;
  logic [addr_w-1:0]    data_addr;
  logic                 data_read_dn;
  logic [data_w-1:0]    data_data;
  logic [data_w-1:0]    data_word;
  logic                 operand_valid;
  logic [3:0]           op_cmd_code;
  logic [reg_num_w-1:0] op_dst_num;
  logic                 op_dst_ptr;
  logic [data_w-1:0]    op_cond;
  logic [data_w-1:0]    op_src1;
  logic [data_w-1:0]    op_src0;
  int unsigned          cmd_delay;
  int unsigned          data_delay;
  int                   cmd_rule_errors;
  int                   data_rule_errors;

  // reference model: fetched commands in order, with the ip after each
  cmd_word_t            fetched_cmd[$];
  logic [data_w-1:0]    fetched_ip[$];
  int                   fetches = 0;
  int                   bundles = 0;
  int                   data_reads = 0;
  int                   mismatches = 0;
  int                   other_errors = 0;
  logic                 run_started = 1'b0;
  logic                 timed_out = 1'b0;
  // fetch in flight, sampled at negedge
  logic                 cmd_busy = 1'b0;

  always #20 clk = ~clk;

  fetch_unit i_fetch_unit (.*);

  tb_mem #(.port_name("instruction port")) i_cmd_mem (
    .clk (clk), .rst (rst), .max_delay (cmd_delay),
    .read_q (cmd_read_q), .addr (cmd_addr), .word (cmd_word),
    .read_dn (cmd_read_dn), .data (cmd_data), .rule_errors (cmd_rule_errors)
  );

  tb_mem #(.port_name("data port")) i_data_mem (
    .clk (clk), .rst (rst), .max_delay (data_delay),
    .read_q (data_read_q), .addr (data_addr), .word (data_word),
    .read_dn (data_read_dn), .data (data_data), .rule_errors (data_rule_errors)
  );

  // integer hash, every address bit counts
  function automatic logic [31:0] mix(input logic [31:0] a);
    logic [31:0] x;
    x = a * 32'h9e37_79b1;
    x = x ^ (x >> 15);
    x = x * 32'h85eb_ca6b;
    return x ^ (x >> 13);
  endfunction

  function automatic logic [31:0] data_at(input logic [31:0] a);
    return mix(a ^ 32'h6a09_e667);
  endfunction

  // random command, unused modify flags pick ip operands about 1 in 4
  function automatic cmd_word_t cmd_at(input logic [31:0] a);
    cmd_word_t c;
    c = cmd_word_t'(mix(a ^ 32'hbb67_ae85));
    if (c.cond_flags == 2'b00) c.cond_num = reg_ip;
    if (c.s1_flags == 2'b00) c.s1_num = reg_ip;
    if (c.s0_flags == 2'b00) c.s0_num = reg_ip;
    return c;
  endfunction

  assign cmd_word = cmd_at(cmd_addr);
  assign data_word = data_at(data_addr);

  // register n at base_addr_data + n, pointer reads one level deeper
  function automatic logic [31:0] operand_value(input logic [3:0] num, input logic ptr,
                                                input logic [31:0] next_ip);
    logic [31:0] v;
    if (num == reg_ip) return next_ip;
    v = data_at(base_addr_data + 32'(num));
    if (ptr) v = data_at(base_addr_data + v);
    return v;
  endfunction

  function automatic int reads_for(input logic [3:0] num, input logic ptr);
    if (num == reg_ip) return 0;
    return ptr ? 2 : 1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bundle();
    cmd_word_t       c;
    logic [31:0]     next_ip;
    operand_bundle_t exp;
    int              exp_reads;
    if (fetched_cmd.size() == 0) begin
      other_errors++;
      $display("%0t: operand_valid with no fetched command left", $time);
    end else begin
      c = fetched_cmd.pop_front();
      next_ip = fetched_ip.pop_front();
      exp.cmd_code = c.cmd_code;
      exp.dst_num = c.d_num;
      exp.dst_ptr = c.d_ptr;
      exp.cond = operand_value(c.cond_num, c.cond_ptr, next_ip);
      exp.src1 = operand_value(c.s1_num, c.s1_ptr, next_ip);
      exp.src0 = operand_value(c.s0_num, c.s0_ptr, next_ip);
      exp_reads = reads_for(c.cond_num, c.cond_ptr) + reads_for(c.s1_num, c.s1_ptr) +
                  reads_for(c.s0_num, c.s0_ptr);
      check_value("op_cmd_code", 32'(op_cmd_code), 32'(exp.cmd_code));
      check_value("op_dst_num", 32'(op_dst_num), 32'(exp.dst_num));
      check_value("op_dst_ptr", 32'(op_dst_ptr), 32'(exp.dst_ptr));
      check_value("op_cond", op_cond, exp.cond);
      check_value("op_src1", op_src1, exp.src1);
      check_value("op_src0", op_src0, exp.src0);
      // ip operands must not touch the data port
      check_value("data reads per command", 32'(data_reads), 32'(exp_reads));
    end
    data_reads = 0;
    bundles++;
  endtask

  // all sampling at negedge, inputs move shortly after posedge
  always @(negedge clk) begin
    if (!rst) begin
      if (!run_started) begin
        assert (!cmd_read_q && !data_read_q && !operand_valid) else begin
          other_errors++;
          $display("%0t: port request or operand_valid before run was raised", $time);
        end
      end
      if (operand_valid) check_bundle();
      if (data_read_q && data_read_dn) data_reads++;
      if (cmd_read_q && cmd_read_dn) begin
        check_value("cmd_addr", cmd_addr, base_addr + 32'(fetches));
        fetched_cmd.push_back(cmd_word_t'(cmd_data));
        fetched_ip.push_back(32'(fetches + 1));
        fetches++;
      end
      // four queued plus one in the operand fetcher
      assert (fetches <= bundles + 5) else begin
        other_errors++;
        $display("%0t: %0d fetches run ahead of %0d bundles", $time, fetches, bundles);
      end
      cmd_busy = cmd_read_q;
    end
  end

  task automatic wait_bundles(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (bundles < target && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (bundles < target) begin
      other_errors++;
      timed_out = 1'b1;
      $display("%0t: timeout, %0d of %0d bundles seen", $time, bundles, target);
    end
  endtask

  // run is low, wait for the last fetch to come out
  task automatic wait_drained(input int limit);
    int cycles;
    cycles = 0;
    while ((fetches != bundles || cmd_busy) && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (fetches != bundles || cmd_busy) begin
      other_errors++;
      timed_out = 1'b1;
      $display("%0t: timeout, fetch unit did not drain after run fell", $time);
    end
  endtask

  initial begin
    void'($urandom(32'h2a17_bccd));
    clk = 1'b0;
    rst = 1'b1;
    run = 1'b0;
    base_addr = 32'h0000_4000;
    base_addr_data = 32'h0010_0000;
    cmd_delay = 3;
    data_delay = 3;
    repeat (3) @(posedge clk);
    #5;
    rst = 1'b0;
    // quiet ports while run is low
    repeat (6) @(posedge clk);
    #5;
    run = 1'b1;
    run_started = 1'b1;
    wait_bundles(40, 4000);
    if (!timed_out) begin
      // slow data port fills the queue
      data_delay = 10;
      wait_bundles(60, 8000);
    end
    if (!timed_out) begin
      @(posedge clk);
      #5;
      run = 1'b0;
      wait_drained(2000);
    end
    if (fetched_cmd.size() != 0) begin
      other_errors++;
      $display("%0d fetched commands never reached operand_valid", fetched_cmd.size());
    end
    $display("%0d bundles, %0d mismatches, %0d other errors, %0d port rule errors",
             bundles, mismatches, other_errors, cmd_rule_errors + data_rule_errors);
    if (mismatches == 0 && other_errors == 0 && cmd_rule_errors + data_rule_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- sources.f
cpu_fetch_pkg.sv
cmd_queue_if.sv
cmd_fetcher.sv
cmd_queue.sv
operand_fetcher.sv
fetch_unit.sv
tb_mem.sv
tb_fetch_unit.sv

//--- run.sh
#!/bin/sh
# build and run the fetch unit testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_fetch_unit \
  -Mdir obj_dir -o tb_fetch_unit
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_fetch_unit > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$log"; then
  exit 0
fi
exit 1
